//--- logic/barrel_shifter16.sv
`default_nettype none
`timescale 1ns/10ps

module barrel_shifter16 (
    input  logic [shifter_pkg::data_w-1:0]  data_in,
    input  logic [shifter_pkg::shamt_w-1:0] shamt,
    input  logic                            dir,
    input  logic                            rotate,
    output logic [shifter_pkg::data_w-1:0]  data_out
);

    localparam int w = shifter_pkg::data_w;

    logic [w-1:0] stage [0:shifter_pkg::shamt_w];
    logic         is_right;

    function automatic logic [w-1:0] bit_rev(input logic [w-1:0] v);
        logic [w-1:0] r;
        for (int k = 0; k < w; k++) begin
            r[k] = v[w-1-k];
        end
        return r;
    endfunction

    assign is_right = (dir == shifter_pkg::dir_right);

    // Right shifts run through the left core mirrored
    assign stage[0] = is_right ? bit_rev(data_in) : data_in;

    for (genvar i = 0; i < shifter_pkg::shamt_w; i++) begin : g_stage
        localparam int s = 1 << i;

        logic [s-1:0] fill;

        // Bits pushed out on the left come back on the right when rotating
        assign fill = (rotate == shifter_pkg::mode_rotate) ? stage[i][w-1 -: s] : '0;
        assign stage[i+1] = shamt[i] ? {stage[i][w-1-s:0], fill} : stage[i];
    end

    assign data_out = is_right ? bit_rev(stage[shifter_pkg::shamt_w])
                               : stage[shifter_pkg::shamt_w];

endmodule

`default_nettype wire

//--- logic/button_toggle.sv
`default_nettype none
`timescale 1ns/10ps

module button_toggle #(
    parameter int debounce_ticks = 10
) (
    input  logic clk_demo,
    input  logic arst_n,
    input  logic tick,
    input  logic btn,
    output logic press,
    output logic state
);

    localparam int cnt_w = $clog2(debounce_ticks + 1);
    localparam logic [cnt_w-1:0] last = cnt_w'(debounce_ticks - 1);

    logic [1:0]       sync_q;
    logic             btn_s;
    logic             stable;
    logic [cnt_w-1:0] cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Synchronizer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_demo or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], btn};
        end
    end

    assign btn_s = sync_q[1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Debounce and toggle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_demo or negedge arst_n) begin
        if (!arst_n) begin
            stable <= 1'b0;
            cnt    <= '0;
            press  <= 1'b0;
            state  <= 1'b0;
        end else begin
            press <= 1'b0;
            if (tick) begin
                if (btn_s == stable) begin
                    // Glitch ended, start over
                    cnt <= '0;
                end else if (cnt == last) begin
                    cnt    <= '0;
                    stable <= btn_s;
                    if (btn_s) begin
                        press <= 1'b1;
                        state <= ~state;
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/display_pkg.sv
`default_nettype none

package display_pkg;

    localparam int digit_count = 8;
    localparam int hex_digits  = 4;

    // Segments are active low, bit 6 is g and bit 0 is a
    localparam int seg_w = 7;
    localparam logic [seg_w-1:0] seg_blank = 7'b111_1111;

    function automatic logic [seg_w-1:0] hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'b100_0000;
            4'h1: return 7'b111_1001;
            4'h2: return 7'b010_0100;
            4'h3: return 7'b011_0000;
            4'h4: return 7'b001_1001;
            4'h5: return 7'b001_0010;
            4'h6: return 7'b000_0010;
            4'h7: return 7'b111_1000;
            4'h8: return 7'b000_0000;
            4'h9: return 7'b001_0000;
            4'ha: return 7'b000_1000;
            4'hb: return 7'b000_0011;
            4'hc: return 7'b100_0110;
            4'hd: return 7'b010_0001;
            4'he: return 7'b000_0110;
            default: return 7'b000_1110;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- logic/seg7_scan.sv
`default_nettype none
`timescale 1ns/10ps

module seg7_scan (
    input  logic                                clk_demo,
    input  logic                                arst_n,
    input  logic                                tick,
    input  logic [shifter_pkg::data_w-1:0]      result,
    output logic [display_pkg::seg_w-1:0]       seg,
    output logic [display_pkg::digit_count-1:0] an
);

    localparam int idx_w = $clog2(display_pkg::digit_count);
    localparam int sel_w = $clog2(display_pkg::hex_digits);

    logic [idx_w-1:0]                     idx;
    logic [sel_w-1:0]                     nib_sel;
    logic [3:0]                           nibble;
    logic [display_pkg::seg_w-1:0]        seg_next;
    logic [display_pkg::digit_count-1:0]  an_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Digit select and decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign nib_sel = idx[sel_w-1:0];
    assign nibble  = result[nib_sel*4 +: 4];

    always_comb begin
        logic [display_pkg::digit_count-1:0] one_hot;
        one_hot      = '0;
        one_hot[idx] = 1'b1;
        an_next      = ~one_hot;
        // Upper positions carry no data
        if (idx < display_pkg::hex_digits) begin
            seg_next = display_pkg::hex_to_seg(nibble);
        end else begin
            seg_next = display_pkg::seg_blank;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scan registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_demo or negedge arst_n) begin
        if (!arst_n) begin
            idx <= '0;
            seg <= display_pkg::seg_blank;
            an  <= '1;
        end else if (tick) begin
            seg <= seg_next;
            an  <= an_next;
            idx <= idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/shift_control.sv
`default_nettype none
`timescale 1ns/10ps

module shift_control #(
    parameter int debounce_ticks = 10
) (
    input  logic                            clk_demo,
    input  logic                            arst_n,
    input  logic                            tick,
    input  logic                            btn_c,
    input  logic                            btn_u,
    input  logic                            btn_d,
    input  logic                            btn_l,
    input  logic                            btn_r,
    output logic [shifter_pkg::shamt_w-1:0] shamt,
    output logic                            dir,
    output logic                            rotate
);

    logic                            c_press;
    logic                            l_state;
    logic                            r_state;
    logic [shifter_pkg::shamt_w-3:0] hi_cnt;

    // Centre button only counts presses
    button_toggle #(.debounce_ticks(debounce_ticks)) i_btn_c (
        .clk_demo (clk_demo),
        .arst_n   (arst_n),
        .tick     (tick),
        .btn      (btn_c),
        .press    (c_press),
        .state    ()
    );

    button_toggle #(.debounce_ticks(debounce_ticks)) i_btn_u (
        .clk_demo (clk_demo),
        .arst_n   (arst_n),
        .tick     (tick),
        .btn      (btn_u),
        .press    (),
        .state    (dir)
    );

    button_toggle #(.debounce_ticks(debounce_ticks)) i_btn_d (
        .clk_demo (clk_demo),
        .arst_n   (arst_n),
        .tick     (tick),
        .btn      (btn_d),
        .press    (),
        .state    (rotate)
    );

    button_toggle #(.debounce_ticks(debounce_ticks)) i_btn_l (
        .clk_demo (clk_demo),
        .arst_n   (arst_n),
        .tick     (tick),
        .btn      (btn_l),
        .press    (),
        .state    (l_state)
    );

    button_toggle #(.debounce_ticks(debounce_ticks)) i_btn_r (
        .clk_demo (clk_demo),
        .arst_n   (arst_n),
        .tick     (tick),
        .btn      (btn_r),
        .press    (),
        .state    (r_state)
    );

    // Upper shift bits wrap modulo four
    always_ff @(posedge clk_demo or negedge arst_n) begin
        if (!arst_n) begin
            hi_cnt <= '0;
        end else if (c_press) begin
            hi_cnt <= hi_cnt + 1'b1;
        end
    end

    assign shamt = {hi_cnt, r_state, l_state};

endmodule

`default_nettype wire

//--- logic/shifter_demo_top.sv
`default_nettype none
`timescale 1ns/10ps

module shifter_demo_top #(
    parameter int tick_div       = 100000,
    parameter int debounce_ticks = 10
) (
    input  logic                                clk_demo,
    input  logic                                arst_n,
    input  logic [shifter_pkg::data_w-1:0]      sw,
    input  logic                                btn_c,
    input  logic                                btn_u,
    input  logic                                btn_d,
    input  logic                                btn_l,
    input  logic                                btn_r,
    output logic [7:0]                          led,
    output logic [display_pkg::seg_w-1:0]       seg,
    output logic [display_pkg::digit_count-1:0] an
);

    logic                            tick;
    logic [shifter_pkg::shamt_w-1:0] shamt;
    logic                            dir;
    logic                            rotate;
    logic [shifter_pkg::data_w-1:0]  result;

    tick_gen #(.tick_div(tick_div)) i_tick_gen (
        .clk_demo (clk_demo),
        .arst_n   (arst_n),
        .tick     (tick)
    );

    shift_control #(.debounce_ticks(debounce_ticks)) i_shift_control (
        .clk_demo (clk_demo),
        .arst_n   (arst_n),
        .tick     (tick),
        .btn_c    (btn_c),
        .btn_u    (btn_u),
        .btn_d    (btn_d),
        .btn_l    (btn_l),
        .btn_r    (btn_r),
        .shamt    (shamt),
        .dir      (dir),
        .rotate   (rotate)
    );

    barrel_shifter16 i_shifter (
        .data_in  (sw),
        .shamt    (shamt),
        .dir      (dir),
        .rotate   (rotate),
        .data_out (result)
    );

    seg7_scan i_scan (
        .clk_demo (clk_demo),
        .arst_n   (arst_n),
        .tick     (tick),
        .result   (result),
        .seg      (seg),
        .an       (an)
    );

    // Shift amount on the top four LEDs, two dark, then mode and direction
    assign led = {shamt, 2'b00, rotate, dir};

endmodule

`default_nettype wire

//--- logic/shifter_pkg.sv
`default_nettype none

package shifter_pkg;

    // Word and shift amount widths
    localparam int data_w  = 16;
    localparam int shamt_w = 4;

    // Direction of the shift, a cleared toggle means left
    localparam logic dir_left  = 1'b0;
    localparam logic dir_right = 1'b1;

    // Logical shift fills with zero, rotate wraps around
    localparam logic mode_shift  = 1'b0;
    localparam logic mode_rotate = 1'b1;

endpackage

`default_nettype wire

//--- logic/tick_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tick_gen #(
    parameter int tick_div = 100000
) (
    input  logic clk_demo,
    input  logic arst_n,
    output logic tick
);

    localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;
    localparam logic [cnt_w-1:0] reload = cnt_w'(tick_div - 1);

    logic [cnt_w-1:0] cnt;

    // One enable pulse per tick_div cycles, first one tick_div cycles after reset
    always_ff @(posedge clk_demo or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= reload;
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= reload;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src.f
logic/shifter_pkg.sv
logic/display_pkg.sv
logic/tick_gen.sv
logic/button_toggle.sv
logic/shift_control.sv
logic/barrel_shifter16.sv
logic/seg7_scan.sv
logic/shifter_demo_top.sv
tests/tb_shifter_demo.sv

//--- tests/tb_shifter_demo.sv
`default_nettype none
`timescale 1ns/10ps

module tb_shifter_demo;

    localparam int tick_div       = 4;
    localparam int debounce_ticks = 3;
    localparam int press_cycles   = (debounce_ticks + 2) * tick_div;
    localparam int wait_limit     = 400;
    localparam int b_c = 0;
    localparam int b_u = 1;
    localparam int b_d = 2;
    localparam int b_l = 3;
    localparam int b_r = 4;

    logic                                clk_demo;
    logic                                arst_n;
    logic [shifter_pkg::data_w-1:0]      sw;
    logic                                btn_c, btn_u, btn_d, btn_l, btn_r;
    logic [7:0]                          led;
    logic [display_pkg::seg_w-1:0]       seg;
    logic [display_pkg::digit_count-1:0] an;

    // Model of the control state
    logic [shifter_pkg::shamt_w-1:0] m_shamt;
    logic                            m_dir;
    logic                            m_rot;
    logic                            check_en;
    int                              seed;
    int                              digits_seen;

    // Inputs as the DUT saw them at the previous rising edge
    logic [display_pkg::digit_count-1:0] an_last;
    logic [shifter_pkg::data_w-1:0]      sw_last;
    logic [shifter_pkg::shamt_w-1:0]     shamt_last;
    logic                                dir_last;
    logic                                rot_last;
    logic                                en_last;
    int                                  idx_last;
    logic                                scan_started;

    shifter_demo_top #(.tick_div(tick_div), .debounce_ticks(debounce_ticks)) i_dut (
        .clk_demo (clk_demo),
        .arst_n   (arst_n),
        .sw       (sw),
        .btn_c    (btn_c),
        .btn_u    (btn_u),
        .btn_d    (btn_d),
        .btn_l    (btn_l),
        .btn_r    (btn_r),
        .led      (led),
        .seg      (seg),
        .an       (an)
    );

    always #2 clk_demo = ~clk_demo;

    task automatic stop_on_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("RESULT: FAIL");
        $fatal(1, "wait expired");
    endtask

    function automatic logic [shifter_pkg::data_w-1:0] ref_shift(
        input logic [shifter_pkg::data_w-1:0] d, input logic [3:0] amt,
        input logic dir, input logic rot);
        logic [shifter_pkg::data_w-1:0] r;
        int a;
        int src;
        a = amt;
        for (int i = 0; i < shifter_pkg::data_w; i++) begin
            src = (dir == shifter_pkg::dir_left) ? i - a : i + a;
            if (src >= 0 && src < shifter_pkg::data_w) begin
                r[i] = d[src];
            end else if (rot == shifter_pkg::mode_rotate) begin
                r[i] = d[(src + shifter_pkg::data_w) % shifter_pkg::data_w];
            end else begin
                r[i] = 1'b0;
            end
        end
        return r;
    endfunction

    function automatic logic [7:0] model_led();
        return {m_shamt, 2'b00, m_rot, m_dir};
    endfunction

    task automatic set_button(input int which, input logic val);
        case (which)
            b_c: btn_c = val;
            b_u: btn_u = val;
            b_d: btn_d = val;
            b_l: btn_l = val;
            default: btn_r = val;
        endcase
    endtask

    task automatic press_button(input int which);
        int waited;
        set_button(which, 1'b1);
        repeat (press_cycles) @(negedge clk_demo);
        set_button(which, 1'b0);
        repeat (press_cycles) @(negedge clk_demo);
        case (which)
            b_c: m_shamt[3:2] = m_shamt[3:2] + 2'd1;
            b_u: m_dir = ~m_dir;
            b_d: m_rot = ~m_rot;
            b_l: m_shamt[0] = ~m_shamt[0];
            default: m_shamt[1] = ~m_shamt[1];
        endcase
        waited = 0;
        while (led !== model_led()) begin
            if (waited >= wait_limit) stop_on_timeout("led did not follow a button press");
            @(negedge clk_demo);
            waited++;
        end
    endtask

    // Too short to pass the debouncer
    task automatic glitch_button(input int which);
        set_button(which, 1'b1);
        repeat ((debounce_ticks - 1) * tick_div - 1) @(negedge clk_demo);
        set_button(which, 1'b0);
        repeat (press_cycles) @(negedge clk_demo);
        assert (led === model_led()) else
            stop_on_error($sformatf("led %b after short pulse, expected %b", led, model_led()));
    endtask

    task automatic wait_digits(input int n);
        int start;
        int waited;
        start  = digits_seen;
        waited = 0;
        while (digits_seen - start < n) begin
            if (waited >= wait_limit) stop_on_timeout("display scan stopped advancing");
            @(negedge clk_demo);
            waited++;
        end
    endtask

    task automatic set_controls(input logic [3:0] amt, input logic dir, input logic rot);
        check_en = 1'b0;
        if (m_shamt[0] != amt[0]) press_button(b_l);
        if (m_shamt[1] != amt[1]) press_button(b_r);
        if (m_dir != dir) press_button(b_u);
        if (m_rot != rot) press_button(b_d);
        while (m_shamt[3:2] != amt[3:2]) press_button(b_c);
        check_en = 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Display checker
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk_demo) begin : display_check
        int idx;
        logic [shifter_pkg::data_w-1:0] exp_word;
        logic [display_pkg::seg_w-1:0]  exp_seg;
        if (!arst_n) begin
            an_last      = '1;
            idx_last     = display_pkg::digit_count - 1;
            scan_started = 1'b0;
        end else begin
            if (an !== an_last) begin
                assert ($countones(~an) == 1) else
                    stop_on_error($sformatf("an %b has not exactly one low bit", an));
                idx = -1;
                for (int k = 0; k < display_pkg::digit_count; k++) begin
                    if (!an[k]) idx = k;
                end
                assert (idx == (idx_last + 1) % display_pkg::digit_count) else
                    stop_on_error($sformatf("digit %0d lit after digit %0d", idx, idx_last));
                if (idx >= display_pkg::hex_digits) begin
                    assert (seg === display_pkg::seg_blank) else
                        stop_on_error($sformatf("digit %0d shows %b, not blank", idx, seg));
                end else if (en_last) begin
                    exp_word = ref_shift(sw_last, shamt_last, dir_last, rot_last);
                    exp_seg  = display_pkg::hex_to_seg(exp_word[idx*4 +: 4]);
                    assert (seg === exp_seg) else
                        stop_on_error($sformatf("digit %0d seg %b, expected %b (sw %h)",
                                                idx, seg, exp_seg, sw_last));
                end
                idx_last     = idx;
                scan_started = 1'b1;
                digits_seen++;
            end
            an_last    = an;
            sw_last    = sw;
            shamt_last = m_shamt;
            dir_last   = m_dir;
            rot_last   = m_rot;
            en_last    = check_en;
        end
    end

    initial begin
        clk_demo    = 1'b0;
        arst_n      = 1'b0;
        sw          = '0;
        btn_c       = 1'b0;
        btn_u       = 1'b0;
        btn_d       = 1'b0;
        btn_l       = 1'b0;
        btn_r       = 1'b0;
        m_shamt     = '0;
        m_dir       = 1'b0;
        m_rot       = 1'b0;
        check_en    = 1'b0;
        en_last     = 1'b0;
        digits_seen = 0;
        seed        = 51196;
        repeat (16) begin
            @(negedge clk_demo);
            assert (led === 8'h00 && an === '1 && seg === display_pkg::seg_blank) else
                stop_on_error($sformatf("in reset led %b an %b seg %b", led, an, seg));
        end
        arst_n = 1'b1;
        wait_digits(10);
        // Toggle buttons and the centre counter
        press_button(b_u);
        press_button(b_d);
        press_button(b_l);
        press_button(b_r);
        press_button(b_u);
        press_button(b_d);
        press_button(b_l);
        press_button(b_r);
        repeat (4) press_button(b_c);
        for (int b = b_c; b <= b_r; b++) glitch_button(b);
        // Every shift amount, direction and mode
        for (int amt = 0; amt < 16; amt++) begin
            for (int d = 0; d < 2; d++) begin
                for (int r = 0; r < 2; r++) begin
                    set_controls(amt[3:0], d[0], r[0]);
                    sw = 16'h8001;
                    wait_digits(9);
                    repeat (2) begin
                        sw = $random(seed);
                        wait_digits(9);
                    end
                end
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
